// ==== rtl/i2s_silence.sv ====
////////////////////////////////////////
// i2s silence generator
// bit clock and word select from the core
// clock, data line held low
////////////////////////////////////////

`timescale 1ns/1ps

module i2s_silence
    import video_pkg::*;
(
    input  logic clk_core_12288,
    input  logic reset_n,
    output logic audio_sclk,
    output logic audio_lrck,
    output logic audio_dac
);

    localparam int unsigned DIV_W  = $clog2(SCLK_DIV);
    localparam int unsigned WORD_W = $clog2(BITS_PER_WORD);

    // bit clock divider, msb is sclk
    logic [DIV_W-1:0] div_cnt;

    // bit clocks within the current slot
    logic [WORD_W-1:0] bit_cnt;

    // last core clock before sclk falls
    logic sclk_fall;

    logic lrck_q;

    assign sclk_fall = (div_cnt == DIV_W'(SCLK_DIV - 1));

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            lrck_q  <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            // lrck changes with the sclk falling edge
            if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                // swap channel after a full 32 bit slot
                if (bit_cnt == WORD_W'(BITS_PER_WORD - 1)) begin
                    lrck_q <= ~lrck_q;
                end
            end
        end
    end

    assign audio_sclk = div_cnt[DIV_W-1];
    assign audio_lrck = lrck_q;

    // silent stream, data line never leaves zero
    assign audio_dac  = 1'b0;

endmodule

// ==== rtl/raster_counter.sv ====
////////////////////////////////////////
// raster counter
// free running h/v position over the
// 400 x 512 frame plus region decode
////////////////////////////////////////

`timescale 1ns/1ps

module raster_counter
    import video_pkg::*;
(
    input  logic     clk_core_12288,
    input  logic     reset_n,
    raster_if.source raster
);

    // position registers
    h_count_t h_pos;
    v_count_t v_pos;

    // wrap points
    logic h_last;
    logic v_last;

    // window hits, per axis
    logic h_in_window;
    logic v_in_window;

    ////////////////////////////////////////
    // position counters
    ////////////////////////////////////////

    assign h_last = (h_pos == H_TOTAL - 1'b1);
    assign v_last = (v_pos == V_TOTAL - 1'b1);

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            h_pos <= '0;
            v_pos <= '0;
        end else begin
            // one pixel per clock
            if (h_last) begin
                h_pos <= '0;
                // next line, wrap at frame end
                if (v_last) begin
                    v_pos <= '0;
                end else begin
                    v_pos <= v_pos + 1'b1;
                end
            end else begin
                h_pos <= h_pos + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // region decode
    ////////////////////////////////////////

    // active window starts right after the back porch on each axis
    assign h_in_window = (h_pos >= H_BPORCH) && (h_pos < H_BPORCH + H_ACTIVE);
    assign v_in_window = (v_pos >= V_BPORCH) && (v_pos < V_BPORCH + V_ACTIVE);

    assign raster.h_pos       = h_pos;
    assign raster.v_pos       = v_pos;
    assign raster.frame_start = (h_pos == '0) && (v_pos == '0);
    assign raster.line_start  = (h_pos == '0);
    assign raster.active      = h_in_window && v_in_window;

    // only raised on lines that carry pixels
    assign raster.line_end = v_in_window && (h_pos == H_BPORCH + H_ACTIVE - 1'b1);

endmodule

// ==== rtl/raster_if.sv ====
////////////////////////////////////////
// raster position bundle
// position and region flags from the
// raster counter to its consumers
////////////////////////////////////////

`timescale 1ns/1ps

interface raster_if
    import video_pkg::*;
();

    // current position in the frame
    h_count_t h_pos;
    v_count_t v_pos;

    // decoded region flags, all combinational from the position
    // position 0,0
    logic frame_start;
    // first clock of every line
    logic line_start;
    // inside both active windows
    logic active;
    // last active pixel of an active line
    logic line_end;

    // counter side
    modport source (
        output h_pos, v_pos, frame_start, line_start, active, line_end
    );

    // consumers only look
    modport sink (
        input h_pos, v_pos, frame_start, line_start, active, line_end
    );

endinterface

// ==== rtl/test_pattern.sv ====
////////////////////////////////////////
// test pattern
// red ramps with the active column, green
// with the active row, blue held constant
////////////////////////////////////////

`timescale 1ns/1ps

module test_pattern
    import video_pkg::*;
(
    input  logic    clk_core_12288,
    input  logic    reset_n,
    raster_if.sink  raster,
    output rgb_t    pattern_rgb
);

    // column inside the active line, 0 to 319
    h_count_t col;

    // row inside the active area, 0 to 239
    v_count_t row;

    // per channel values
    pixel_t red;
    pixel_t green;
    pixel_t blue;

    ////////////////////////////////////////
    // active column and row
    ////////////////////////////////////////

    // counters follow the interface flags only,
    // no window compares repeated here
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (raster.frame_start) begin
            // new frame, restart both ramps
            col <= '0;
            row <= '0;
        end else if (raster.line_end) begin
            // last pixel shown, move to next row
            col <= '0;
            row <= row + 1'b1;
        end else if (raster.active) begin
            col <= col + 1'b1;
        end
    end

    // blanking lines leave row alone,
    // so green equals the active row index

    ////////////////////////////////////////
    // colour
    ////////////////////////////////////////

    // red wraps every 256 columns
    assign red   = col[7:0];
    assign green = row[7:0];
    assign blue  = PATTERN_BLUE;

    // valid for the current position, registered downstream
    assign pattern_rgb = {red, green, blue};

endmodule

// ==== rtl/video_core_top.sv ====
////////////////////////////////////////
// video core top level
// raster counter, test pattern, output
// stage and silent i2s stream
////////////////////////////////////////

`timescale 1ns/1ps

module video_core_top
    import video_pkg::*;
(
    input  logic        clk_core_12288,
    input  logic        reset_n,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs,
    output logic        audio_sclk,
    output logic        audio_lrck,
    output logic        audio_dac
);

    // shared raster position and flags
    raster_if raster ();

    // pattern colour for the current position
    rgb_t pattern_rgb;

    ////////////////////////////////////////
    // video path
    ////////////////////////////////////////

    raster_counter raster_counter_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .raster         (raster.source)
    );

    test_pattern test_pattern_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .raster         (raster.sink),
        .pattern_rgb    (pattern_rgb)
    );

    // one clock behind the counter
    video_out video_out_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .raster         (raster.sink),
        .pattern_rgb    (pattern_rgb),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs)
    );

    ////////////////////////////////////////
    // audio
    ////////////////////////////////////////

    i2s_silence i2s_silence_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

endmodule

// ==== rtl/video_out.sv ====
////////////////////////////////////////
// video output stage
// one register stage toward the scaler:
// rgb with blanking, de, hs and vs
////////////////////////////////////////

`timescale 1ns/1ps

module video_out
    import video_pkg::*;
(
    input  logic    clk_core_12288,
    input  logic    reset_n,
    raster_if.sink  raster,
    input  rgb_t    pattern_rgb,
    output rgb_t    video_rgb,
    output logic    video_de,
    output logic    video_hs,
    output logic    video_vs
);

    // registered outputs
    rgb_t rgb_q;
    logic de_q;
    logic hs_q;
    logic vs_q;

    // hs point in the line
    logic hs_hit;

    assign hs_hit = (raster.h_pos == HS_OFFSET);

    ////////////////////////////////////////
    // sync and enable
    ////////////////////////////////////////

    // all one clock behind the raster position
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            vs_q <= 1'b0;
            hs_q <= 1'b0;
            de_q <= 1'b0;
        end else begin
            // single clock pulse per frame, in the back porch
            vs_q <= raster.frame_start;
            // single clock pulse per line, 3 clocks after line start
            hs_q <= hs_hit;
            de_q <= raster.active;
        end
    end

    ////////////////////////////////////////
    // pixel data
    ////////////////////////////////////////

    // outside the active window the scaler sees black
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            rgb_q <= '0;
        end else if (raster.active) begin
            rgb_q <= pattern_rgb;
        end else begin
            rgb_q <= '0;
        end
    end

    // rgb lands with de on the same clock
    assign video_rgb = rgb_q;
    assign video_de  = de_q;
    assign video_hs  = hs_q;
    assign video_vs  = vs_q;

endmodule

// ==== rtl/video_pkg.sv ====
////////////////////////////////////////
// video core shared definitions
// raster geometry, pattern level, i2s framing
// and the width types used across the core
////////////////////////////////////////

package video_pkg;

    ////////////////////////////////////////
    // width types
    ////////////////////////////////////////

    // horizontal position, 0 to 399
    typedef logic [9:0] h_count_t;

    // vertical position, 0 to 511
    typedef logic [9:0] v_count_t;

    // one colour channel
    typedef logic [7:0] pixel_t;

    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    ////////////////////////////////////////
    // raster geometry
    ////////////////////////////////////////

    // 400 x 512 at 12.288 MHz gives 204800 clocks per frame, 60 Hz
    localparam h_count_t H_TOTAL  = 10'd400;
    localparam h_count_t H_BPORCH = 10'd10;
    localparam h_count_t H_ACTIVE = 10'd320;

    localparam v_count_t V_TOTAL  = 10'd512;
    localparam v_count_t V_BPORCH = 10'd10;
    localparam v_count_t V_ACTIVE = 10'd240;

    // hs sits a few clocks into the line
    // so it never lands on the same cycle as vs
    localparam h_count_t HS_OFFSET = 10'd3;

    ////////////////////////////////////////
    // test pattern
    ////////////////////////////////////////

    // fixed blue level under the red/green ramps
    localparam pixel_t PATTERN_BLUE = 8'd64;

    ////////////////////////////////////////
    // i2s framing
    ////////////////////////////////////////

    // core clocks per bit clock, 12.288 MHz down to 3.072 MHz
    localparam int unsigned SCLK_DIV = 4;

    // bit clocks per channel slot, 64 per lrck period, 48 kHz
    localparam int unsigned BITS_PER_WORD = 32;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the video core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_video_core -o sim_tb

# the simulator exit code is not trusted, the log decides
./obj_dir/sim_tb 2>&1 | tee sim.log || true

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== src.f ====
rtl/video_pkg.sv
rtl/raster_if.sv
rtl/raster_counter.sv
rtl/test_pattern.sv
rtl/video_out.sv
rtl/i2s_silence.sv
rtl/video_core_top.sv
testbench/tb_video_core.sv

// ==== testbench/tb_video_core.sv ====
////////////////////////////////////////
// video core testbench
// runs two full frames and checks raster
// timing, test pattern and i2s framing
////////////////////////////////////////

`timescale 1ns/1ps

module tb_video_core;

    // expected geometry, straight from the frame spec
    localparam int FRAME_CLKS = 204800;
    localparam int LINE_CLKS  = 400;
    localparam int LINES      = 512;
    localparam int HS_DELAY   = 3;
    localparam int DE_DELAY   = 7;
    localparam int ACTIVE_W   = 320;
    localparam int ACTIVE_H   = 240;
    localparam int SCLK_HALF  = 2;
    localparam int LRCK_HALF  = 128;
    localparam int WAIT_LIMIT = FRAME_CLKS + 16;

    logic clk_core_12288 = 1'b0;
    logic reset_n = 1'b0;

    logic [23:0] video_rgb;
    logic video_de;
    logic video_hs;
    logic video_vs;
    logic audio_sclk;
    logic audio_lrck;
    logic audio_dac;

    // no random stimulus here, inputs are clock and reset only
    int seed = 32'h5604;
    int errors = 0;

    // high from the first clock after reset release
    logic run_en = 1'b0;

    // observed timing state, updated on the falling edge
    int since_vs = 0;
    int since_hs = 0;
    int hs_count = 0;
    int de_run = 0;
    int rows_done = 0;
    logic vs_seen = 1'b0;
    logic hs_seen = 1'b0;

    // audio edge tracking
    int sclk_age = 0;
    int lrck_age = 0;
    logic sclk_prev = 1'b0;
    logic lrck_prev = 1'b0;
    logic sclk_sync = 1'b0;
    logic lrck_sync = 1'b0;
    logic sclk_toggle;
    logic lrck_toggle;

    logic [29:0] out_bits;
    logic [23:0] exp_rgb;

    always #50 clk_core_12288 = ~clk_core_12288;

    video_core_top dut_i (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    assign out_bits = {video_rgb, video_de, video_hs, video_vs,
                       audio_sclk, audio_lrck, audio_dac};
    assign sclk_toggle = (audio_sclk != sclk_prev);
    assign lrck_toggle = (audio_lrck != lrck_prev);

    // column = de clocks so far in this line, row = finished de lines
    assign exp_rgb = {de_run[7:0], rows_done[7:0], 8'd64};

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic wait_vs(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk_core_12288);
            n++;
        end while (!video_vs && n < limit);
        if (!video_vs) begin
            $display("Timeout: no vs pulse within %0d clocks", limit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    endtask

    ////////////////////////////////////////
    // output tracking
    ////////////////////////////////////////

    always @(posedge clk_core_12288) begin
        run_en <= reset_n;
    end

    // outputs settle after the rising edge, so look on the falling one
    always @(negedge clk_core_12288) begin
        if (run_en) begin
            since_vs <= video_vs ? 1 : since_vs + 1;
            since_hs <= video_hs ? 1 : since_hs + 1;
            vs_seen <= vs_seen | video_vs;
            hs_seen <= hs_seen | video_hs;
            hs_count <= video_vs ? 0 : (video_hs ? hs_count + 1 : hs_count);
            de_run <= video_de ? de_run + 1 : 0;
            // a de run just ended
            if (video_vs) begin
                rows_done <= 0;
            end else if (!video_de && de_run != 0) begin
                rows_done <= rows_done + 1;
            end
            sclk_age <= sclk_toggle ? 1 : sclk_age + 1;
            lrck_age <= lrck_toggle ? 1 : lrck_age + 1;
            sclk_prev <= audio_sclk;
            lrck_prev <= audio_lrck;
            sclk_sync <= sclk_sync | sclk_toggle;
            lrck_sync <= lrck_sync | lrck_toggle;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // everything low in reset, up to the first clock out of it
    assert property (@(negedge clk_core_12288) !run_en |-> out_bits == '0)
        else report_mismatch("reset quiet", 0, int'($sampled(out_bits)));

    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        video_vs && vs_seen |-> since_vs == FRAME_CLKS)
        else report_mismatch("vs period", FRAME_CLKS, $sampled(since_vs));
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        video_vs && vs_seen |-> hs_count == LINES)
        else report_mismatch("hs per frame", LINES, $sampled(hs_count));
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        video_hs && hs_seen |-> since_hs == LINE_CLKS)
        else report_mismatch("hs period", LINE_CLKS, $sampled(since_hs));
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        video_hs && vs_seen && hs_count == 0 |-> since_vs == HS_DELAY)
        else report_mismatch("hs after vs", HS_DELAY, $sampled(since_vs));

    // active window
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        video_de && de_run == 0 |-> since_hs == DE_DELAY)
        else report_mismatch("de after hs", DE_DELAY, $sampled(since_hs));
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        !video_de && de_run != 0 |-> de_run == ACTIVE_W)
        else report_mismatch("de run length", ACTIVE_W, $sampled(de_run));
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        video_vs && vs_seen |-> rows_done == ACTIVE_H)
        else report_mismatch("de lines per frame", ACTIVE_H, $sampled(rows_done));
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        !video_de |-> video_rgb == '0)
        else report_mismatch("rgb blanking", 0, int'($sampled(video_rgb)));

    // pattern colour
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        video_de && vs_seen |-> video_rgb == exp_rgb)
        else report_mismatch("pattern rgb", int'($sampled(exp_rgb)),
                             int'($sampled(video_rgb)));

    // audio framing
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        sclk_sync |-> (sclk_toggle ? sclk_age == SCLK_HALF : sclk_age < SCLK_HALF))
        else report_mismatch("sclk half period", SCLK_HALF, $sampled(sclk_age));
    assert property (@(negedge clk_core_12288) disable iff (!run_en)
        lrck_sync |-> (lrck_toggle ? lrck_age == LRCK_HALF : lrck_age < LRCK_HALF))
        else report_mismatch("lrck half period", LRCK_HALF, $sampled(lrck_age));
    assert property (@(negedge clk_core_12288) disable iff (!run_en) !audio_dac)
        else report_mismatch("dac data", 0, int'($sampled(audio_dac)));

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        repeat (5) @(negedge clk_core_12288);
        reset_n = 1'b1;
        // first vs, then two full frames
        wait_vs(WAIT_LIMIT);
        wait_vs(WAIT_LIMIT);
        wait_vs(WAIT_LIMIT);
        // let the last frame checks fire
        repeat (4) @(negedge clk_core_12288);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
